/* all.f */
source/me_geom_pkg.sv
source/me_data_pkg.sv
source/me_input_stage.sv
source/me_abs_diff.sv
source/me_sad_array.sv
source/me_best_match.sv
source/me_vector_out.sv
source/me_top.sv
bench/tb_me_top.sv

/* bench/tb_me_top.sv */
module tb_me_top;

    import me_geom_pkg::*;
    import me_data_pkg::*;

    logic   clk;
    logic   rst_n;
    logic   block_valid;
    logic   area_valid;
    pixel_t in_data;
    logic   out_valid;
    mv_t    out_vector;

    int     seed = 56981;
    int     errors;
    int     timeouts;
    int     frames_sent;
    int     vectors_checked;

    // frame under test, as plain integers
    int     blk  [BLOCK_PIX];
    int     area [AREA_DIM * AREA_DIM];
    int     model_x;
    int     model_y;
    mv_t    exp_q [$];
    mv_t    exp_v;

    // edges since the 64th area pixel was sampled
    int     area_seen;
    int     since_last = 100;

    me_top me_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .area_valid  (area_valid),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_vector  (out_vector)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    function automatic int rand_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    function automatic int pixel_distance(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // ----------------------------------------------------------------------
    // reference model, full search with later candidate winning ties
    // ----------------------------------------------------------------------
    task automatic run_model();
        int sad;
        int best_sad;
        int best_r;
        int best_c;
        best_sad = 0;
        best_r   = 0;
        best_c   = 0;
        for (int r = 0; r < CAND_DIM; r++)
        begin
            for (int c = 0; c < CAND_DIM; c++)
            begin
                sad = 0;
                for (int i = 0; i < BLOCK_DIM; i++)
                begin
                    for (int j = 0; j < BLOCK_DIM; j++)
                        sad += pixel_distance(area[(r + i) * AREA_DIM + c + j],
                                              blk[i * BLOCK_DIM + j]);
                end
                if ((r == 0 && c == 0) || sad <= best_sad)
                begin
                    best_sad = sad;
                    best_r   = r;
                    best_c   = c;
                end
            end
        end
        model_x = best_c - SEARCH_RANGE;
        model_y = SEARCH_RANGE - best_r;
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic idle_gap(input int gap_max);
        int n;
        n = (gap_max > 0) ? rand_below(gap_max + 1) : 0;
        repeat (n)
        begin
            @(posedge clk);
            block_valid <= 1'b0;
            area_valid  <= 1'b0;
        end
    endtask

    task automatic wait_vector();
        int n;
        n = 0;
        while (!out_valid && n < 200)
        begin
            @(posedge clk);
            n++;
        end
        if (!out_valid)
        begin
            timeouts++;
            $display("timeout: out_valid did not rise within 200 cycles of a frame");
        end
        n = 0;
        while (out_valid && n < 200)
        begin
            @(posedge clk);
            n++;
        end
        if (out_valid)
        begin
            timeouts++;
            $display("timeout: out_valid stayed high for 200 cycles");
        end
    endtask

    task automatic send_frame(input int gap_max, input int exp_x, input int exp_y);
        exp_q.push_back(mv_t'(exp_x));
        exp_q.push_back(mv_t'(exp_y));
        frames_sent++;
        for (int k = 0; k < BLOCK_PIX; k++)
        begin
            idle_gap(gap_max);
            @(posedge clk);
            block_valid <= 1'b1;
            area_valid  <= 1'b0;
            in_data     <= pixel_t'(blk[k]);
        end
        for (int p = 0; p < AREA_DIM * AREA_DIM; p++)
        begin
            idle_gap(gap_max);
            @(posedge clk);
            block_valid <= 1'b0;
            area_valid  <= 1'b1;
            in_data     <= pixel_t'(area[p]);
        end
        @(posedge clk);
        area_valid <= 1'b0;
        in_data    <= '0;
        wait_vector();
    endtask

    task automatic random_frame();
        for (int k = 0; k < BLOCK_PIX; k++)
            blk[k] = rand_below(256);
        for (int p = 0; p < AREA_DIM * AREA_DIM; p++)
            area[p] = rand_below(256);
    endtask

    // block below 128, background above, so only the planted spot gives zero
    task automatic planted_frame(input int r0, input int c0);
        for (int k = 0; k < BLOCK_PIX; k++)
            blk[k] = rand_below(128);
        for (int p = 0; p < AREA_DIM * AREA_DIM; p++)
            area[p] = 128 + rand_below(128);
        for (int i = 0; i < BLOCK_DIM; i++)
        begin
            for (int j = 0; j < BLOCK_DIM; j++)
                area[(r0 + i) * AREA_DIM + c0 + j] = blk[i * BLOCK_DIM + j];
        end
    endtask

    // ----------------------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------------------
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            area_seen  = 0;
            since_last = 100;
        end
        else
        begin
            if (since_last < 100)
                since_last++;
            if (area_valid)
            begin
                area_seen++;
                if (area_seen == AREA_DIM * AREA_DIM)
                begin
                    area_seen  = 0;
                    since_last = 0;
                end
            end
        end
        check_valid: assert (out_valid == (since_last == 4 || since_last == 5))
        else
        begin
            errors++;
            $display("FAIL at time %0t: out_valid is %0b, %0d edges after last area pixel",
                     $time, out_valid, since_last);
        end
        if (since_last == 4 || since_last == 5)
        begin
            exp_v = exp_q.size() > 0 ? exp_q.pop_front() : '0;
            vectors_checked++;
            check_vector: assert (out_vector == exp_v)
            else
            begin
                errors++;
                $display("FAIL at time %0t: vector %s is %0d, expected %0d", $time,
                         (since_last == 4) ? "x" : "y", out_vector, exp_v);
            end
        end
    end

    quiet_vector: assert property (@(posedge clk) !out_valid |-> out_vector == '0)
    else
    begin
        errors++;
        $display("FAIL at time %0t: out_vector is %0d while out_valid is low",
                 $time, out_vector);
    end

    initial
    begin
        int r0;
        int c0;
        rst_n           = 1'b0;
        block_valid     = 1'b0;
        area_valid      = 1'b0;
        in_data         = '0;
        errors          = 0;
        timeouts        = 0;
        frames_sent     = 0;
        vectors_checked = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);

        // same frame without and with idle gaps
        for (int f = 0; f < 4; f++)
        begin
            random_frame();
            run_model();
            send_frame(0, model_x, model_y);
            send_frame(3, model_x, model_y);
        end

        // the planted offset itself is the expected vector
        for (int f = 0; f < 5; f++)
        begin
            r0 = rand_below(CAND_DIM);
            c0 = rand_below(CAND_DIM);
            planted_frame(r0, c0);
            send_frame(f % 3, c0 - SEARCH_RANGE, SEARCH_RANGE - r0);
        end

        // flat frame, every candidate ties, last one wins
        for (int k = 0; k < BLOCK_PIX; k++)
            blk[k] = 50;
        for (int p = 0; p < AREA_DIM * AREA_DIM; p++)
            area[p] = 80;
        send_frame(0, 2, -2);

        repeat (10) @(posedge clk);
        $display("frames: %0d, vectors checked: %0d, errors: %0d, timeouts: %0d",
                 frames_sent, vectors_checked, errors, timeouts);
        if (errors == 0 && timeouts == 0 && vectors_checked == 2 * frames_sent)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the motion estimator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_me_top -o sim_me \
    && ./obj_dir/sim_me > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

/* source/me_abs_diff.sv */
module me_abs_diff (
    input  logic                    clk,
    input  logic                    rst_n,
    input  me_data_pkg::block_t     block,
    input  me_data_pkg::area_pix_t  area_pix,
    output me_data_pkg::diff_beat_t diff_beat
);

    import me_geom_pkg::*;
    import me_data_pkg::*;

    block_t    diff_next;
    block_t    diff_q;
    area_pos_t pos_q;
    logic      valid_q;

    // all 16 differences in parallel
    always_comb
    begin
        for (int k = 0; k < BLOCK_PIX; k++)
        begin
            if (block[k] > area_pix.pix)
                diff_next[k] = block[k] - area_pix.pix;
            else
                diff_next[k] = area_pix.pix - block[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= area_pix.valid;
    end

    always_ff @(posedge clk)
    begin
        if (area_pix.valid)
        begin
            pos_q  <= area_pix.pos;
            diff_q <= diff_next;
        end
    end

    assign diff_beat = '{valid: valid_q, pos: pos_q, diff: diff_q};

endmodule

/* source/me_best_match.sv */
module me_best_match (
    input  logic                   clk,
    input  logic                   rst_n,
    input  me_data_pkg::cand_sad_t cand_sad,
    output me_data_pkg::best_mv_t  best_mv
);

    import me_geom_pkg::*;
    import me_data_pkg::*;

    sad_t      best_sad;
    cand_idx_t best_idx;
    logic      take;
    logic      last;
    cand_idx_t win_idx;

    logic      mv_valid;
    mv_t       mv_x;
    mv_t       mv_y;

    // first candidate always loads, later ones win ties
    assign take    = (cand_sad.idx == '0) || (cand_sad.sad <= best_sad);
    assign last    = cand_sad.idx == cand_idx_t'(NUM_CAND - 1);
    assign win_idx = take ? cand_sad.idx : best_idx;

    always_ff @(posedge clk)
    begin
        if (cand_sad.valid && take)
        begin
            best_sad <= cand_sad.sad;
            best_idx <= cand_sad.idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mv_valid <= 1'b0;
        else
            mv_valid <= cand_sad.valid && last;
    end

    // column maps to x, row maps to y with up positive
    always_ff @(posedge clk)
    begin
        if (cand_sad.valid && last)
        begin
            mv_x <= mv_t'(int'(win_idx) % CAND_DIM - SEARCH_RANGE);
            mv_y <= mv_t'(SEARCH_RANGE - int'(win_idx) / CAND_DIM);
        end
    end

    assign best_mv = '{valid: mv_valid, mv_x: mv_x, mv_y: mv_y};

endmodule

/* source/me_data_pkg.sv */
package me_data_pkg;

    import me_geom_pkg::*;

    // ----------------------------------------------------------------------
    // scalar types
    // ----------------------------------------------------------------------
    typedef logic [7:0]        pixel_t;

    // 16 x 255 = 4080 at most
    typedef logic [11:0]       sad_t;

    // one vector component, -2 to +2
    typedef logic signed [2:0] mv_t;

    // whole current block, slot k holds raster pixel k
    typedef pixel_t [BLOCK_PIX-1:0] block_t;

    // ----------------------------------------------------------------------
    // stage to stage beats, each a one cycle strobe with its data
    // ----------------------------------------------------------------------

    // area pixel tagged with its raster position
    typedef struct packed {
        logic      valid;
        area_pos_t pos;
        pixel_t    pix;
    } area_pix_t;

    // one area pixel against all block pixels
    typedef struct packed {
        logic                   valid;
        area_pos_t              pos;
        pixel_t [BLOCK_PIX-1:0] diff;
    } diff_beat_t;

    // finished SAD of one candidate
    typedef struct packed {
        logic      valid;
        cand_idx_t idx;
        sad_t      sad;
    } cand_sad_t;

    typedef struct packed {
        logic valid;
        mv_t  mv_x;
        mv_t  mv_y;
    } best_mv_t;

endpackage

/* source/me_geom_pkg.sv */
package me_geom_pkg;

    // ----------------------------------------------------------------------
    // search geometry
    // ----------------------------------------------------------------------

    // current block side in pixels
    localparam int BLOCK_DIM    = 4;

    // search area side in pixels
    localparam int AREA_DIM     = 8;

    // largest vector magnitude in either direction
    localparam int SEARCH_RANGE = 2;

    // candidate offsets per side, and in total
    localparam int CAND_DIM     = AREA_DIM - BLOCK_DIM + 1;
    localparam int NUM_CAND     = CAND_DIM * CAND_DIM;

    localparam int BLOCK_PIX    = BLOCK_DIM * BLOCK_DIM;

    // ----------------------------------------------------------------------
    // index types
    // ----------------------------------------------------------------------

    // raster slot inside the current block
    typedef logic [$clog2(BLOCK_PIX)-1:0] block_idx_t;

    // raster position inside the area, wraps at the end of a frame
    typedef logic [$clog2(AREA_DIM * AREA_DIM)-1:0] area_pos_t;

    // candidate number in raster order, row * CAND_DIM + col
    typedef logic [$clog2(NUM_CAND)-1:0] cand_idx_t;

endpackage

/* source/me_input_stage.sv */
module me_input_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   block_valid,
    input  logic                   area_valid,
    input  me_data_pkg::pixel_t    in_data,
    output me_data_pkg::block_t    block,
    output logic                   block_start,
    output me_data_pkg::area_pix_t area_pix
);

    import me_geom_pkg::*;
    import me_data_pkg::*;

    block_idx_t block_cnt;
    area_pos_t  area_cnt;

    // ----------------------------------------------------------------------
    // position counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            block_cnt   <= '0;
            area_cnt    <= '0;
            block_start <= 1'b0;
        end
        else
        begin
            // one pulse per new block
            block_start <= block_valid && (block_cnt == '0);
            if (block_valid)
                block_cnt <= block_cnt + 1'b1;
            // wrap at 64 lines up the next frame
            if (area_valid)
                area_cnt <= area_cnt + 1'b1;
        end
    end

    // block buffer
    always_ff @(posedge clk)
    begin
        if (block_valid)
            block[block_cnt] <= in_data;
    end

    // area pixel goes on with its raster position, same cycle
    always_comb
    begin
        area_pix.valid = area_valid;
        area_pix.pos   = area_cnt;
        area_pix.pix   = in_data;
    end

endmodule

/* source/me_sad_array.sv */
module me_sad_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    block_start,
    input  me_data_pkg::diff_beat_t diff_beat,
    output me_data_pkg::cand_sad_t  cand_sad
);

    import me_geom_pkg::*;
    import me_data_pkg::*;

    logic [2:0] area_row;
    logic [2:0] area_col;
    int         row_ofs;
    int         col_ofs;
    logic       done;
    cand_idx_t  done_idx;

    sad_t       acc      [NUM_CAND];
    sad_t       acc_next [NUM_CAND];

    logic       cand_valid;
    cand_idx_t  cand_idx;
    sad_t       cand_sum;

    assign area_row = 3'(diff_beat.pos / AREA_DIM);
    assign area_col = 3'(diff_beat.pos % AREA_DIM);

    // ----------------------------------------------------------------------
    // accumulators
    // ----------------------------------------------------------------------
    // candidate (r, c) covers area rows r..r+3 and columns c..c+3; the beat
    // adds the difference against the block pixel it falls on
    for (genvar r = 0; r < CAND_DIM; r++)
    begin : g_row
        for (genvar c = 0; c < CAND_DIM; c++)
        begin : g_col
            int         dr;
            int         dc;
            logic       hit;
            block_idx_t sel;

            assign dr  = int'(area_row) - r;
            assign dc  = int'(area_col) - c;
            assign hit = diff_beat.valid && dr >= 0 && dr < BLOCK_DIM
                         && dc >= 0 && dc < BLOCK_DIM;
            assign sel = block_idx_t'(dr * BLOCK_DIM + dc);

            assign acc_next[r * CAND_DIM + c] =
                acc[r * CAND_DIM + c] + sad_t'(diff_beat.diff[sel]);

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    acc[r * CAND_DIM + c] <= '0;
                else if (block_start)
                    acc[r * CAND_DIM + c] <= '0;
                else if (hit)
                    acc[r * CAND_DIM + c] <= acc_next[r * CAND_DIM + c];
            end
        end
    end

    // ----------------------------------------------------------------------
    // completion
    // ----------------------------------------------------------------------
    // the candidate whose bottom right corner is this pixel is finished
    assign row_ofs  = int'(area_row) - (BLOCK_DIM - 1);
    assign col_ofs  = int'(area_col) - (BLOCK_DIM - 1);
    assign done     = diff_beat.valid && row_ofs >= 0 && col_ofs >= 0;
    assign done_idx = cand_idx_t'(row_ofs * CAND_DIM + col_ofs);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cand_valid <= 1'b0;
        else
            cand_valid <= done;
    end

    always_ff @(posedge clk)
    begin
        if (done)
        begin
            cand_idx <= done_idx;
            cand_sum <= acc_next[done_idx];
        end
    end

    assign cand_sad = '{valid: cand_valid, idx: cand_idx, sad: cand_sum};

endmodule

/* source/me_top.sv */
module me_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                block_valid,
    input  logic                area_valid,
    input  me_data_pkg::pixel_t in_data,
    output logic                out_valid,
    output me_data_pkg::mv_t    out_vector
);

    import me_data_pkg::*;

    block_t     block;
    logic       block_start;
    area_pix_t  area_pix;
    diff_beat_t diff_beat;
    cand_sad_t  cand_sad;
    best_mv_t   best_mv;

    // ----------------------------------------------------------------------
    // pipeline, one area pixel per stage
    // ----------------------------------------------------------------------
    me_input_stage u_input_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .area_valid  (area_valid),
        .in_data     (in_data),
        .block       (block),
        .block_start (block_start),
        .area_pix    (area_pix)
    );

    me_abs_diff u_abs_diff (
        .clk       (clk),
        .rst_n     (rst_n),
        .block     (block),
        .area_pix  (area_pix),
        .diff_beat (diff_beat)
    );

    me_sad_array u_sad_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_start (block_start),
        .diff_beat   (diff_beat),
        .cand_sad    (cand_sad)
    );

    me_best_match u_best_match (
        .clk      (clk),
        .rst_n    (rst_n),
        .cand_sad (cand_sad),
        .best_mv  (best_mv)
    );

    me_vector_out u_vector_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .best_mv    (best_mv),
        .out_valid  (out_valid),
        .out_vector (out_vector)
    );

endmodule

/* source/me_vector_out.sv */
module me_vector_out (
    input  logic                  clk,
    input  logic                  rst_n,
    input  me_data_pkg::best_mv_t best_mv,
    output logic                  out_valid,
    output me_data_pkg::mv_t      out_vector
);

    import me_data_pkg::*;

    // state names what the port carries right now
    typedef enum logic [1:0] {
        IDLE,
        SEND_X,
        SEND_Y
    } state_t;

    state_t state;
    mv_t    hold_y;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            out_valid  <= 1'b0;
            out_vector <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (best_mv.valid)
                    begin
                        state      <= SEND_X;
                        out_valid  <= 1'b1;
                        out_vector <= best_mv.mv_x;
                    end
                end
                SEND_X:
                begin
                    state      <= SEND_Y;
                    out_vector <= hold_y;
                end
                SEND_Y:
                begin
                    state      <= IDLE;
                    out_valid  <= 1'b0;
                    out_vector <= '0;
                end
                default:
                begin
                    state      <= IDLE;
                    out_valid  <= 1'b0;
                    out_vector <= '0;
                end
            endcase
        end
    end

    // y waits one cycle behind x
    always_ff @(posedge clk)
    begin
        if (best_mv.valid)
            hold_y <= best_mv.mv_y;
    end

endmodule
